// File: verilog.f
source/bp_pkg.sv
source/bp_table.sv
source/bp_lookup.sv
source/bp_resolve.sv
source/bp_csr_apb.sv
source/branch_predictor.sv
verification/branch_predictor_checker.sv
verification/branch_predictor_tb.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --timing --assert --timescale 1ns/100ps
TOP        = branch_predictor_tb
FILE_LIST  = verilog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = All checks passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/branch_predictor_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module branch_predictor_tb;

	logic                clock;
	logic                reset;
	bp_pkg::fetch_req_t  fetch;
	bp_pkg::resolve_t    resolve;
	bp_pkg::apb_req_t    apb_req;
	bp_pkg::prediction_t predict;
	bp_pkg::redirect_t   redirect;
	bp_pkg::apb_rsp_t    apb_rsp;

	integer      seed;
	int          errors;
	int          checks;
	logic [31:0] pc_a;  // Branch used by the install and counter tests
	logic [31:0] tgt_a;

	// Reference model, BTB rows, direction counters and event counts
	logic        m_valid   [16];
	logic [9:0]  m_tag     [16];
	logic [11:0] m_target  [16];
	logic [1:0]  m_counter [64];
	logic        m_enable;
	int          m_lookups;
	int          m_hits;
	int          m_mispredicts;

	branch_predictor u_branch_predictor (
		.clock    (clock),
		.reset    (reset),
		.fetch    (fetch),
		.resolve  (resolve),
		.apb_req  (apb_req),
		.predict  (predict),
		.redirect (redirect),
		.apb_rsp  (apb_rsp)
	);

	bind branch_predictor branch_predictor_checker u_checker (
		.clock    (clock),
		.reset    (reset),
		.fetch    (fetch),
		.predict  (predict),
		.redirect (redirect),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	task automatic next_cycle(); // Inputs change 1 ns after the edge
		@(posedge clock);
		#1;
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] actual,
	                          input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	function automatic bp_pkg::prediction_t make_pred(input logic taken,
	                                                  input logic [31:0] target);
		bp_pkg::prediction_t p;
		p.taken  = taken;
		p.target = target;
		return p;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 16; i++) begin
			m_valid[i]  = 1'b0;
			m_tag[i]    = 10'd0;
			m_target[i] = 12'd0;
		end
		for (int i = 0; i < 64; i++) begin
			m_counter[i] = 2'd1; // Weakly not taken
		end
		m_enable      = 1'b0;
		m_lookups     = 0;
		m_hits        = 0;
		m_mispredicts = 0;
	endtask

	function automatic logic model_hit(input logic [31:0] pc, input logic is_branch);
		return m_enable && is_branch && m_valid[pc[5:2]] && (m_tag[pc[5:2]] == pc[15:6]);
	endfunction

	function automatic bp_pkg::prediction_t model_predict(input logic [31:0] pc,
	                                                      input logic is_branch);
		bp_pkg::prediction_t p;
		p.taken  = model_hit(pc, is_branch) && m_counter[pc[7:2]][1];
		p.target = p.taken ? {pc[31:14], m_target[pc[5:2]], 2'b00} : pc + 32'd4;
		return p;
	endfunction

	function automatic logic model_mispredict(input bp_pkg::prediction_t pred, input logic taken,
	                                          input logic [31:0] target);
		return m_enable && ((pred.taken != taken) ||
		                    (pred.taken && taken && (pred.target != target)));
	endfunction

	task automatic model_resolve(input logic [31:0] pc, input logic taken,
	                             input logic [31:0] target);
		if (m_enable) begin
			if (taken && (m_counter[pc[7:2]] != 2'd3)) begin
				m_counter[pc[7:2]] = m_counter[pc[7:2]] + 2'd1;
			end else if (!taken && (m_counter[pc[7:2]] != 2'd0)) begin
				m_counter[pc[7:2]] = m_counter[pc[7:2]] - 2'd1;
			end
			if (taken) begin // Not taken keeps the BTB row
				m_valid[pc[5:2]]  = 1'b1;
				m_tag[pc[5:2]]    = pc[15:6];
				m_target[pc[5:2]] = target[13:2];
			end
		end
	endtask

	task automatic do_fetch(input logic [31:0] pc, input logic is_branch);
		bp_pkg::prediction_t expected;
		fetch.valid     = 1'b1;
		fetch.pc        = pc;
		fetch.is_branch = is_branch;
		#1;
		expected = model_predict(pc, is_branch);
		check_bit("predict.taken", predict.taken, expected.taken);
		check_word("predict.target", predict.target, expected.target);
		if (m_enable && is_branch) m_lookups++;
		if (model_hit(pc, is_branch)) m_hits++;
		next_cycle();
		fetch.valid = 1'b0;
	endtask

	task automatic do_resolve(input logic [31:0] pc, input logic taken, input logic [31:0] target,
	                          input bp_pkg::prediction_t pred);
		logic exp_mis;
		resolve.valid         = 1'b1;
		resolve.pc            = pc;
		resolve.actual_taken  = taken;
		resolve.actual_target = target;
		resolve.predicted     = pred;
		#1;
		exp_mis = model_mispredict(pred, taken, target);
		check_bit("redirect.mispredict", redirect.mispredict, exp_mis);
		check_word("redirect.pc", redirect.pc, taken ? target : pc + 32'd4);
		if (exp_mis) m_mispredicts++;
		model_resolve(pc, taken, target);
		next_cycle(); // Tables update on this edge
		resolve.valid = 1'b0;
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
	                            output logic [31:0] rdata, output logic slverr);
		int waited;
		int limit;
		limit           = 8;
		apb_req.psel    = 1'b1; // Setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		next_cycle();
		apb_req.penable = 1'b1;
		#1;
		waited = 0;
		while (!apb_rsp.pready) begin
			if (waited == limit) begin
				$display("APB transfer at address %h never saw pready", addr);
				$display("Checks failed");
				$finish;
			end
			next_cycle();
			waited++;
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		next_cycle();
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic expect_err);
		logic [31:0] rdata;
		logic        slverr;
		apb_transfer(1'b1, addr, data, rdata, slverr);
		check_bit("pslverr", slverr, expect_err);
		// Ctrl write sets enable and clears every event count
		if (addr == bp_pkg::reg_ctrl) begin
			m_enable      = data[0];
			m_lookups     = 0;
			m_hits        = 0;
			m_mispredicts = 0;
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected,
	                        input logic expect_err, input string name);
		logic [31:0] rdata;
		logic        slverr;
		apb_transfer(1'b0, addr, 32'd0, rdata, slverr);
		check_bit("pslverr", slverr, expect_err);
		if (!expect_err) check_word(name, rdata, expected);
	endtask

	task automatic check_counter(input logic [31:0] pc, input logic [1:0] expected);
		check_word("bht counter", 32'(u_branch_predictor.u_bht.table_q[pc[7:2]]), 32'(expected));
	endtask

	task automatic test_reset_state();
		apb_read(bp_pkg::reg_ctrl, 32'd0, 1'b0, "reg_ctrl");
		apb_read(bp_pkg::reg_lookups, 32'd0, 1'b0, "reg_lookups");
		apb_read(bp_pkg::reg_hits, 32'd0, 1'b0, "reg_hits");
		apb_read(bp_pkg::reg_mispredicts, 32'd0, 1'b0, "reg_mispredicts");
		do_fetch(pc_a, 1'b1); // Disabled, so pc + 4
		apb_read(bp_pkg::reg_lookups, 32'd0, 1'b0, "reg_lookups"); // Held while disabled
	endtask

	task automatic test_install();
		apb_write(bp_pkg::reg_ctrl, 32'd1, 1'b0);
		do_fetch(pc_a, 1'b1); // Cold miss
		do_resolve(pc_a, 1'b1, tgt_a, make_pred(1'b0, pc_a + 32'd4));
		check_counter(pc_a, 2'd2);
		do_fetch(pc_a, 1'b1);
		do_fetch(pc_a ^ 32'h0000_0400, 1'b1); // Same BTB row and taken counter, other tag
	endtask

	task automatic test_counters();
		for (int i = 0; i < 2; i++) begin
			do_resolve(pc_a, 1'b0, pc_a + 32'd4, model_predict(pc_a, 1'b1));
		end
		check_counter(pc_a, 2'd0);
		check_bit("btb valid", u_branch_predictor.u_btb.table_q[pc_a[5:2]].valid, 1'b1);
		do_fetch(pc_a, 1'b1); // Hit but strongly not taken
		for (int i = 0; i < 4; i++) begin // One more than needed to reach 3
			do_resolve(pc_a, 1'b1, tgt_a, model_predict(pc_a, 1'b1));
		end
		check_counter(pc_a, 2'd3);
		do_fetch(pc_a, 1'b1);
	endtask

	task automatic test_redirect();
		logic [31:0] pc_b;
		logic [31:0] tgt_b;
		pc_b  = 32'h0000_20C8;
		tgt_b = 32'h0000_2400;
		do_resolve(pc_b, 1'b0, pc_b + 32'd4, make_pred(1'b1, tgt_b));         // Wrong direction
		do_resolve(pc_b, 1'b1, tgt_b, make_pred(1'b0, pc_b + 32'd4));
		do_resolve(pc_b, 1'b1, tgt_b, make_pred(1'b1, tgt_b + 32'h100));      // Wrong target
		do_resolve(pc_b, 1'b1, tgt_b, make_pred(1'b1, tgt_b));                // Correct
		do_resolve(pc_b, 1'b0, pc_b + 32'd4, make_pred(1'b0, pc_b + 32'd4));
	endtask

	task automatic test_registers();
		logic [31:0] rnd;
		logic [31:0] pc;
		logic [31:0] target;
		apb_write(bp_pkg::reg_ctrl, 32'd1, 1'b0);
		for (int i = 0; i < 40; i++) begin
			rnd    = $random(seed);
			pc     = 32'h0000_3000 | (rnd & 32'h0000_005C); // Rows 0 to 7, two tags
			target = {18'd0, 2'b11, rnd[17:8], 2'b00};
			if (rnd[31]) begin
				do_fetch(pc, rnd[21] | rnd[22]);
			end else begin
				do_resolve(pc, rnd[20], rnd[20] ? target : pc + 32'd4, model_predict(pc, 1'b1));
			end
		end
		apb_read(bp_pkg::reg_lookups, 32'(m_lookups), 1'b0, "reg_lookups");
		apb_read(bp_pkg::reg_hits, 32'(m_hits), 1'b0, "reg_hits");
		apb_read(bp_pkg::reg_mispredicts, 32'(m_mispredicts), 1'b0, "reg_mispredicts");
		apb_write(bp_pkg::reg_ctrl, 32'd1, 1'b0);
		apb_read(bp_pkg::reg_ctrl, 32'd1, 1'b0, "reg_ctrl");
		apb_read(bp_pkg::reg_lookups, 32'd0, 1'b0, "reg_lookups");
		apb_read(bp_pkg::reg_hits, 32'd0, 1'b0, "reg_hits");
		apb_read(bp_pkg::reg_mispredicts, 32'd0, 1'b0, "reg_mispredicts");
		apb_read(8'h10, 32'd0, 1'b1, "unmapped");
		apb_write(bp_pkg::reg_hits, 32'd5, 1'b1); // Read-only, ignored
		apb_read(bp_pkg::reg_hits, 32'd0, 1'b0, "reg_hits");
	endtask

	task automatic test_forwarding();
		logic [31:0] pc_f;
		logic [31:0] tgt_f;
		logic        exp_mis;
		pc_f  = 32'h0000_70A0; // Untouched BHT row, counter still 1
		tgt_f = 32'h0000_7300;
		resolve.valid         = 1'b1;
		resolve.pc            = pc_f;
		resolve.actual_taken  = 1'b1;
		resolve.actual_target = tgt_f;
		resolve.predicted     = make_pred(1'b0, pc_f + 32'd4);
		fetch.valid           = 1'b1;
		fetch.pc              = pc_f;
		fetch.is_branch       = 1'b1;
		#1;
		exp_mis = model_mispredict(resolve.predicted, 1'b1, tgt_f);
		check_bit("redirect.mispredict", redirect.mispredict, exp_mis);
		check_bit("forwarded predict.taken", predict.taken, 1'b1);
		check_word("forwarded predict.target", predict.target, tgt_f);
		model_resolve(pc_f, 1'b1, tgt_f);
		next_cycle();
		fetch.valid   = 1'b0;
		resolve.valid = 1'b0;
	endtask

	initial begin
		seed    = 32'h4197ee0c;
		errors  = 0;
		checks  = 0;
		reset   = 1'b1;
		fetch   = '0;
		resolve = '0;
		apb_req = '0;
		pc_a    = 32'h0000_1044; // Row 1, tag 0x41
		tgt_a   = 32'h0000_1200;
		model_reset();
		@(posedge clock);
		#1;
		// Mispredicting resolve held in reset, redirect must stay quiet
		resolve.valid         = 1'b1;
		resolve.pc            = pc_a;
		resolve.actual_taken  = 1'b1;
		resolve.actual_target = tgt_a;
		resolve.predicted     = make_pred(1'b0, pc_a + 32'd4);
		repeat (4) @(posedge clock);
		#1;
		reset         = 1'b0;
		resolve.valid = 1'b0;

		test_reset_state();
		test_install();
		test_counters();
		test_redirect();
		test_registers();
		test_forwarding();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/branch_predictor_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module branch_predictor_checker (
	input wire logic                clock,
	input wire logic                reset,
	input wire bp_pkg::fetch_req_t  fetch,
	input wire bp_pkg::prediction_t predict,
	input wire bp_pkg::redirect_t   redirect,
	input wire bp_pkg::apb_req_t    apb_req,
	input wire bp_pkg::apb_rsp_t    apb_rsp
);

	// No redirect may leave the predictor while it is held in reset
	redirect_quiet_in_reset: assert property (
		@(posedge clock) reset |-> !redirect.mispredict
	) else $error("redirect.mispredict high during reset");

	// A taken prediction only ever answers a valid branch fetch
	taken_needs_branch_fetch: assert property (
		@(posedge clock) disable iff (reset)
		predict.taken |-> (fetch.valid && fetch.is_branch)
	) else $error("predict.taken without a valid branch fetch");

	// Zero wait states, pready tracks the access phase exactly
	pready_tracks_access: assert property (
		@(posedge clock) disable iff (reset)
		apb_rsp.pready == (apb_req.psel && apb_req.penable)
	) else $error("pready does not follow psel and penable");

endmodule

`default_nettype wire

// File: source/branch_predictor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module branch_predictor (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire bp_pkg::fetch_req_t  fetch,
	input  wire bp_pkg::resolve_t    resolve,
	input  wire bp_pkg::apb_req_t    apb_req,

	output      bp_pkg::prediction_t predict,
	output      bp_pkg::redirect_t   redirect,
	output      bp_pkg::apb_rsp_t    apb_rsp
);

	logic                                enable;
	logic [bp_pkg::btb_index_width-1:0]  btb_fetch_index;
	logic [bp_pkg::bht_index_width-1:0]  bht_fetch_index;
	logic [bp_pkg::bht_index_width-1:0]  bht_resolve_index;
	bp_pkg::btb_entry_t                  btb_fetch_entry;
	bp_pkg::counter_t                    bht_fetch_counter;
	bp_pkg::counter_t                    bht_resolve_counter;
	logic                                btb_write_en;
	logic [bp_pkg::btb_index_width-1:0]  btb_write_index;
	bp_pkg::btb_entry_t                  btb_write_data;
	logic                                bht_write_en;
	bp_pkg::counter_t                    bht_write_data;
	logic                                lookup_event;
	logic                                hit_event;
	logic                                mispredict_event;

	bp_table #(
		.entry_t     (bp_pkg::btb_entry_t),
		.depth       (bp_pkg::btb_rows),
		.reset_entry (bp_pkg::btb_entry_reset)
	) u_btb (
		.clock        (clock),
		.reset        (reset),
		.write_en     (btb_write_en),
		.write_index  (btb_write_index),
		.write_data   (btb_write_data),
		.read_index_a (btb_fetch_index),
		.read_index_b (btb_write_index), // Resolver never reads the BTB
		.read_data_a  (btb_fetch_entry),
		.read_data_b  ()
	);

	bp_table #(
		.entry_t     (bp_pkg::counter_t),
		.depth       (bp_pkg::bht_rows),
		.reset_entry (bp_pkg::counter_reset)
	) u_bht (
		.clock        (clock),
		.reset        (reset),
		.write_en     (bht_write_en),
		.write_index  (bht_resolve_index),
		.write_data   (bht_write_data),
		.read_index_a (bht_fetch_index),
		.read_index_b (bht_resolve_index),
		.read_data_a  (bht_fetch_counter),
		.read_data_b  (bht_resolve_counter)
	);

	bp_lookup u_lookup (
		.fetch        (fetch),
		.enable       (enable),
		.btb_entry    (btb_fetch_entry),
		.bht_counter  (bht_fetch_counter),
		.btb_index    (btb_fetch_index),
		.bht_index    (bht_fetch_index),
		.predict      (predict),
		.lookup_event (lookup_event),
		.hit_event    (hit_event)
	);

	bp_resolve u_resolve (
		.resolve          (resolve),
		.enable           (enable),
		.bht_counter      (bht_resolve_counter),
		.bht_index        (bht_resolve_index),
		.btb_write_en     (btb_write_en),
		.btb_write_index  (btb_write_index),
		.btb_write_data   (btb_write_data),
		.bht_write_en     (bht_write_en),
		.bht_write_data   (bht_write_data),
		.redirect         (redirect),
		.mispredict_event (mispredict_event)
	);

	bp_csr_apb u_csr (
		.clock            (clock),
		.reset            (reset),
		.apb_req          (apb_req),
		.lookup_event     (lookup_event),
		.hit_event        (hit_event),
		.mispredict_event (mispredict_event),
		.apb_rsp          (apb_rsp),
		.enable           (enable)
	);

endmodule

`default_nettype wire

// File: source/bp_csr_apb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Predictor control and event registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module bp_csr_apb (
	input  wire logic             clock,
	input  wire logic             reset,
	input  wire bp_pkg::apb_req_t apb_req,
	input  wire logic             lookup_event,     // One-cycle strobes
	input  wire logic             hit_event,
	input  wire logic             mispredict_event,

	output      bp_pkg::apb_rsp_t apb_rsp,
	output      logic             enable
);

	logic        access;
	logic        mapped;
	logic        read_only;
	logic        ctrl_write;
	logic [31:0] lookups_q;
	logic [31:0] hits_q;
	logic [31:0] mispredicts_q;
	logic [31:0] read_data;

	assign access = apb_req.psel & apb_req.penable; // Access phase, no wait states

	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b1;
		read_data = 32'd0;
		case (apb_req.paddr)
			bp_pkg::reg_ctrl: begin
				read_only = 1'b0;
				read_data = {31'd0, enable};
			end
			bp_pkg::reg_lookups:     read_data = lookups_q;
			bp_pkg::reg_hits:        read_data = hits_q;
			bp_pkg::reg_mispredicts: read_data = mispredicts_q;
			default:                 mapped = 1'b0;
		endcase
	end

	assign ctrl_write = access & apb_req.pwrite & (apb_req.paddr == bp_pkg::reg_ctrl);

	always_comb begin
		apb_rsp.pready  = access;
		apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & read_only));
		apb_rsp.prdata  = (access & ~apb_req.pwrite) ? read_data : 32'd0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			enable <= 1'b0;
		end else if (ctrl_write) begin
			enable <= apb_req.pwdata[0]; // Upper bits ignored
		end
	end

	// Wrapping counters, any ctrl write clears all three
	always_ff @(posedge clock) begin
		if (reset || ctrl_write) begin
			lookups_q     <= 32'd0;
			hits_q        <= 32'd0;
			mispredicts_q <= 32'd0;
		end else begin
			if (lookup_event)     lookups_q     <= lookups_q + 32'd1;
			if (hit_event)        hits_q        <= hits_q + 32'd1;
			if (mispredict_event) mispredicts_q <= mispredicts_q + 32'd1;
		end
	end

endmodule

`default_nettype wire

// File: source/bp_resolve.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute-side branch resolver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module bp_resolve (
	input  wire bp_pkg::resolve_t                        resolve,
	input  wire logic                                    enable,
	input  wire bp_pkg::counter_t                        bht_counter, // Stored counter at bht_index

	output      logic [bp_pkg::bht_index_width-1:0]      bht_index,
	output      logic                                    btb_write_en,
	output      logic [bp_pkg::btb_index_width-1:0]      btb_write_index,
	output      bp_pkg::btb_entry_t                      btb_write_data,
	output      logic                                    bht_write_en,
	output      bp_pkg::counter_t                        bht_write_data,
	output      bp_pkg::redirect_t                       redirect,
	output      logic                                    mispredict_event
);

	localparam int tag_lsb = bp_pkg::btb_index_width + 2;
	localparam int tag_msb = tag_lsb + bp_pkg::tag_width - 1;
	localparam int tgt_msb = bp_pkg::target_width + 1;

	logic        update;
	logic        dir_wrong;
	logic        target_wrong;
	logic [31:0] seq_pc;

	assign update = enable & resolve.valid;

	assign bht_index       = resolve.pc[bp_pkg::bht_index_width+1:2];
	assign btb_write_index = resolve.pc[bp_pkg::btb_index_width+1:2];

	// One step toward the outcome, saturating at both ends
	always_comb begin
		bht_write_data = bht_counter;
		if (resolve.actual_taken) begin
			if (bht_counter != bp_pkg::counter_max) begin
				bht_write_data = bht_counter + 2'd1;
			end
		end else if (bht_counter != bp_pkg::counter_min) begin
			bht_write_data = bht_counter - 2'd1;
		end
	end

	assign bht_write_en = update;

	// Taken branches install or refresh their entry
	// Not taken leaves the BTB row alone
	assign btb_write_en = update & resolve.actual_taken;

	always_comb begin
		btb_write_data.valid  = 1'b1;
		btb_write_data.tag    = resolve.pc[tag_msb:tag_lsb];
		btb_write_data.target = resolve.actual_target[tgt_msb:2];
	end

	assign dir_wrong    = resolve.predicted.taken != resolve.actual_taken;
	assign target_wrong = resolve.predicted.taken & resolve.actual_taken &
	                      (resolve.predicted.target != resolve.actual_target);

	assign seq_pc = resolve.pc + 32'd4;

	always_comb begin
		redirect.mispredict = update & (dir_wrong | target_wrong);
		redirect.pc         = resolve.actual_taken ? resolve.actual_target : seq_pc;
	end

	assign mispredict_event = redirect.mispredict;

endmodule

`default_nettype wire

// File: source/bp_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch-side prediction lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module bp_lookup (
	input  wire bp_pkg::fetch_req_t                      fetch,
	input  wire logic                                    enable,
	input  wire bp_pkg::btb_entry_t                      btb_entry,   // Entry at btb_index
	input  wire bp_pkg::counter_t                        bht_counter, // Counter at bht_index

	output      logic [bp_pkg::btb_index_width-1:0]      btb_index,
	output      logic [bp_pkg::bht_index_width-1:0]      bht_index,
	output      bp_pkg::prediction_t                     predict,
	output      logic                                    lookup_event,
	output      logic                                    hit_event
);

	localparam int tag_lsb = bp_pkg::btb_index_width + 2;
	localparam int tag_msb = tag_lsb + bp_pkg::tag_width - 1;
	localparam int tgt_msb = bp_pkg::target_width + 1;

	logic [bp_pkg::tag_width-1:0] fetch_tag;
	logic                         branch_fetch;
	logic                         hit;
	logic [31:0]                  seq_pc;
	logic [31:0]                  btb_target;

	// Word-aligned PC, low two bits never index
	assign btb_index = fetch.pc[bp_pkg::btb_index_width+1:2];
	assign bht_index = fetch.pc[bp_pkg::bht_index_width+1:2];
	assign fetch_tag = fetch.pc[tag_msb:tag_lsb];

	assign branch_fetch = enable & fetch.valid & fetch.is_branch;
	assign hit          = branch_fetch & btb_entry.valid & (btb_entry.tag == fetch_tag);

	assign seq_pc = fetch.pc + 32'd4;

	// Upper bits borrowed from the fetch PC, only PC[13:2] is stored
	always_comb begin
		btb_target                 = fetch.pc;
		btb_target[tgt_msb:2]      = btb_entry.target;
		btb_target[1:0]            = 2'b00;
	end

	always_comb begin
		predict.taken  = hit & bht_counter[1]; // Weakly or strongly taken
		predict.target = predict.taken ? btb_target : seq_pc;
	end

	assign lookup_event = branch_fetch;
	assign hit_event    = hit;

endmodule

`default_nettype wire

// File: source/bp_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped prediction table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module bp_table #(
	parameter type    entry_t     = logic,
	parameter int     depth       = 16,
	parameter entry_t reset_entry = '0
) (
	input  wire logic                     clock,
	input  wire logic                     reset,

	input  wire logic                     write_en,
	input  wire logic [$clog2(depth)-1:0] write_index,
	input  wire entry_t                   write_data,

	input  wire logic [$clog2(depth)-1:0] read_index_a, // Fetch side
	input  wire logic [$clog2(depth)-1:0] read_index_b, // Read-modify-write side
	output      entry_t                   read_data_a,
	output      entry_t                   read_data_b
);

	entry_t table_q [depth];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				table_q[i] <= reset_entry;
			end
		end else if (write_en) begin
			table_q[write_index] <= write_data;
		end
	end

	// Port a sees a write in the same cycle, so a fetch of a branch that
	// resolves right now already uses the updated entry
	always_comb begin
		if (write_en && (write_index == read_index_a)) begin
			read_data_a = write_data;
		end else begin
			read_data_a = table_q[read_index_a];
		end
	end

	// Port b feeds the writer itself, forwarding here would close a loop
	assign read_data_b = table_q[read_index_b];

endmodule

`default_nettype wire

// File: source/bp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package bp_pkg;

	// BTB geometry, index from PC[5:2], tag from PC[15:6]
	localparam int btb_rows        = 16;
	localparam int btb_index_width = 4;
	localparam int tag_width       = 10;
	localparam int target_width    = 12; // Target keeps PC[13:2] only

	// Direction table, index from PC[7:2]
	localparam int bht_rows        = 64;
	localparam int bht_index_width = 6;

	typedef struct packed {
		logic                    valid;
		logic [tag_width-1:0]    tag;
		logic [target_width-1:0] target;
	} btb_entry_t;

	// 2-bit saturating counter, bit 1 set means predict taken
	typedef logic [1:0] counter_t;
	localparam counter_t counter_min   = 2'd0; // Strongly not taken
	localparam counter_t counter_reset = 2'd1; // Weakly not taken
	localparam counter_t counter_max   = 2'd3; // Strongly taken

	localparam btb_entry_t btb_entry_reset = '0;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        is_branch;
	} fetch_req_t;

	typedef struct packed {
		logic        taken;
		logic [31:0] target; // pc + 4 when not taken
	} prediction_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        actual_taken;
		logic [31:0] actual_target;
		prediction_t predicted; // Prediction made when this branch was fetched
	} resolve_t;

	typedef struct packed {
		logic        mispredict;
		logic [31:0] pc;
	} redirect_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Register map
	localparam logic [7:0] reg_ctrl        = 8'h00;
	localparam logic [7:0] reg_lookups     = 8'h04;
	localparam logic [7:0] reg_hits        = 8'h08;
	localparam logic [7:0] reg_mispredicts = 8'h0C;

endpackage

`default_nettype wire
